// ==== bench/nfc_if_trace.txt ====
# kind (0 cmd, 1 addr, 2 write, 3 read), total_cycle, high_cycle, command, col, row, count
# then four data words; all fields hex, unused fields zero
0 3 2 70 00000000 00000000 0 0000 0000 0000 0000
1 3 2 00 04030201 0c0b0a09 5 0000 0000 0000 0000
2 3 2 00 00000000 00000000 4 a5c3 1234 ffff 0001
3 3 2 00 00000000 00000000 4 5a3c 8001 7e7e 0f0f
0 5 6 ff 00000000 00000000 0 0000 0000 0000 0000
1 5 6 00 deadbeef 00c0ffee 8 0000 0000 0000 0000
2 5 6 00 00000000 00000000 3 0bad f00d 4321 0000
3 5 6 00 00000000 00000000 3 c001 beef 1357 0000
1 5 6 00 87654321 00000000 1 0000 0000 0000 0000

// ==== compile.f ====
design/nfc_pkg.sv
design/nfif_seq_fsm.sv
design/nfif_strobe_gen.sv
design/nfif_addr_byte_sel.sv
design/nfif_data_path.sv
design/nfc_if_top.sv
bench/nfc_if_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the NAND flash sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module nfc_if_tb \
    --Mdir obj_dir -o nfc_if_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/nfc_if_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TB PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== bench/nfc_if_tb.sv ====
/* Trace-driven testbench for the NAND flash bus sequencer
   Reads bench/nfc_if_trace.txt, models the flash and memory sides, checks pins and results */
module nfc_if_tb
    import nfc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DAT_WID = 16;
    localparam int MAX_OPS = 16;
    localparam int TIMEOUT = 4000;
    localparam nf_pins_t IDLE_PINS = '{cle: 1'b0, ale: 1'b0, web: 1'b1, reb: 1'b1, dir: 1'b0};

    logic                    clk_2x;
    logic                    rst_n;
    nfc_req_t                req;
    logic [CMD_WID-1:0]      if_cmd;
    logic [31:0]             col_addr;
    logic [31:0]             row_addr;
    logic [ADDR_CNT_WID-1:0] addr_cnt;
    logic [DAT_CNT_WID-1:0]  dat_cnt;
    nfc_tconf_t              tconf;
    nfif_status_t            status;
    logic [DAT_WID-1:0]      nf_din;
    logic [DAT_WID-1:0]      nf_dout;
    nf_pins_t                pins;
    logic                    dat_rdy;
    logic                    mem_wr;
    logic [DAT_WID-1:0]      mem_din;
    logic                    sink_rdy;
    logic                    data_wr;
    logic [DAT_WID-1:0]      data_out;

    // One trace entry per operation
    int op_kind [MAX_OPS];
    int op_t    [MAX_OPS];
    int op_h    [MAX_OPS];
    int op_arg  [MAX_OPS];
    int op_col  [MAX_OPS];
    int op_row  [MAX_OPS];
    int op_cnt  [MAX_OPS];
    int op_w    [MAX_OPS][4];
    int num_ops;

    // Current operation as seen by the bus monitor and the models
    int                 kind;
    int                 cur_t;
    int                 cur_h;
    logic [DAT_WID-1:0] exp_words [4];
    logic [CMD_WID-1:0] exp_bytes [8];
    int we_rises;
    int re_rises;
    int rdy_rises;
    int wr_pulses;
    int done_pulses;
    int low_len;
    int since_fall;
    bit have_fall;
    int src_idx;
    int stall;
    bit src_busy;
    nf_pins_t prev_pins;
    logic     sink_s;
    logic     dat_rdy_s;

    int mismatch_errs;
    int other_errs;

    nfc_if_top #(
        .DAT_WID (DAT_WID)
    ) DUT (
        .clk_2x   (clk_2x),
        .rst_n    (rst_n),
        .req      (req),
        .if_cmd   (if_cmd),
        .col_addr (col_addr),
        .row_addr (row_addr),
        .addr_cnt (addr_cnt),
        .dat_cnt  (dat_cnt),
        .tconf    (tconf),
        .status   (status),
        .nf_din   (nf_din),
        .nf_dout  (nf_dout),
        .pins     (pins),
        .dat_rdy  (dat_rdy),
        .mem_wr   (mem_wr),
        .mem_din  (mem_din),
        .sink_rdy (sink_rdy),
        .data_wr  (data_wr),
        .data_out (data_out)
    );

    initial
    begin
        clk_2x = 1'b0;
        forever #50 clk_2x = ~clk_2x;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_pins(input nf_pins_t got, input nf_pins_t exp, input string name);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_status(input nfif_status_t got, input nfif_status_t exp,
                                input string name);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_word(input logic [DAT_WID-1:0] got, input logic [DAT_WID-1:0] exp,
                              input string name);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp)
        begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    //////////////////////////////
    // Bus monitor
    //////////////////////////////
    always @(negedge clk_2x)
    begin
        if (rst_n)
        begin
            if (!prev_pins.web && pins.web)
            begin
                check_count(low_len, cur_h + 1, "web low width");
                if (kind == 0)
                begin
                    check_pins(pins, '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1}, "pins at web rise");
                    check_word(nf_dout, exp_words[0], "nf_dout command");
                end
                else if (kind == 1)
                begin
                    check_pins(pins, '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1}, "pins at web rise");
                    if (we_rises < 8)
                        check_word(nf_dout, DAT_WID'(exp_bytes[we_rises]), "nf_dout address");
                end
                else if (kind == 2)
                begin
                    check_pins(pins, '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1}, "pins at web rise");
                    if (we_rises < 4)
                        check_word(nf_dout, exp_words[we_rises], "nf_dout write data");
                end
                we_rises++;
            end
            if (!prev_pins.reb && pins.reb)
            begin
                check_count(low_len, cur_h + 1, "reb low width");
                check_pins(pins, '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0}, "pins at reb rise");
                re_rises++;
            end
            if ((prev_pins.web && !pins.web) || (prev_pins.reb && !pins.reb))
            begin
                if (kind == 1 && have_fall)
                    check_count(since_fall, 2 * cur_t + 2, "address bus cycle length");
                if (prev_pins.reb && !pins.reb && !sink_s)
                begin
                    $display("Error at %0t: RE# fell while the sink was not ready", $time);
                    other_errs++;
                end
                since_fall = 0;
                have_fall  = 1'b1;
            end
            // Source stall keeps WE# high
            if (dat_rdy && !pins.web)
            begin
                $display("Error at %0t: WE# low while waiting for a write word", $time);
                other_errs++;
            end
            // A new request follows a full write bus cycle
            if (dat_rdy && !dat_rdy_s)
            begin
                if (have_fall)
                    check_count(since_fall, 2 * cur_t + 2, "write bus cycle length");
                rdy_rises++;
            end
            if (data_wr)
            begin
                if (wr_pulses < 4)
                    check_word(data_out, exp_words[wr_pulses], "data_out");
                wr_pulses++;
            end
            // Done sits in the last clock of the final bus cycle
            if (status != '0)
            begin
                check_status(status, (kind == 0) ? 3'b100 : (kind == 1) ? 3'b010 : 3'b001,
                             "status");
                check_count(since_fall, 2 * cur_t + 1, "final bus cycle length");
                done_pulses++;
            end
            low_len = (!pins.web || !pins.reb) ? low_len + 1 : 0;
            since_fall++;
        end
        prev_pins = pins;
        sink_s    = sink_rdy;
        dat_rdy_s = dat_rdy;
    end

    //////////////////////////////
    // Flash, write source and sink models
    //////////////////////////////
    always @(posedge clk_2x)
    begin
        nf_din <= (re_rises < 4) ? exp_words[re_rises] : '0;
        sink_rdy <= (kind == 3) && (($urandom % 3) != 0);
        mem_wr <= 1'b0;
        if (!dat_rdy_s)
            src_busy <= 1'b0;
        else if (!src_busy)
        begin
            if (stall > 0)
                stall <= stall - 1;
            else
            begin
                mem_wr   <= 1'b1;
                mem_din  <= exp_words[src_idx % 4];
                src_idx  <= src_idx + 1;
                src_busy <= 1'b1;
                stall    <= int'($urandom % 4);
            end
        end
    end

    task automatic read_trace();
        int    fd;
        int    n;
        string line;
        fd = $fopen("bench/nfc_if_trace.txt", "r");
        num_ops = 0;
        if (fd == 0)
        begin
            $display("Error: cannot open the trace file");
            other_errs++;
            return;
        end
        while (!$feof(fd) && num_ops < MAX_OPS)
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", op_kind[num_ops],
                            op_t[num_ops], op_h[num_ops], op_arg[num_ops], op_col[num_ops],
                            op_row[num_ops], op_cnt[num_ops], op_w[num_ops][0],
                            op_w[num_ops][1], op_w[num_ops][2], op_w[num_ops][3]);
                if (n == 11)
                    num_ops++;
            end
        end
        $fclose(fd);
    endtask

    // Runs one operation from request to idle and clears ok on a timeout
    task automatic run_op(input int i, output bit ok);
        int cnt;
        int idle_run;
        ok = 1'b1;
        @(posedge clk_2x);
        kind  = op_kind[i];
        cur_t = op_t[i];
        cur_h = op_h[i];
        for (int k = 0; k < 4; k++)
            exp_words[k] = (kind == 0) ? DAT_WID'(op_arg[i]) : DAT_WID'(op_w[i][k]);
        for (int k = 0; k < 8; k++)
            exp_bytes[k] = (k < 4) ? CMD_WID'(op_col[i] >> (8 * k))
                                   : CMD_WID'(op_row[i] >> (8 * (k - 4)));
        we_rises    = 0;
        re_rises    = 0;
        rdy_rises   = 0;
        wr_pulses   = 0;
        done_pulses = 0;
        have_fall   = 1'b0;
        src_idx     = 0;
        stall       = int'($urandom % 4);
        if_cmd   <= CMD_WID'(op_arg[i]);
        col_addr <= op_col[i];
        row_addr <= op_row[i];
        addr_cnt <= ADDR_CNT_WID'(op_cnt[i]);
        dat_cnt  <= DAT_CNT_WID'(op_cnt[i]);
        tconf    <= '{total_cycle: 3'(op_t[i]), high_cycle: 4'(op_h[i])};
        req      <= '{cmd_en: kind == 0, addr_en: kind == 1, dat_en: kind >= 2,
                      dat_dir: kind == 2};
        cnt = 0;
        while (status == '0 && cnt < TIMEOUT)
        begin
            @(negedge clk_2x);
            cnt++;
        end
        if (cnt >= TIMEOUT)
        begin
            $display("Error: timeout waiting for the done pulse of operation %0d", i);
            other_errs++;
            ok = 1'b0;
            return;
        end
        // Samples after the drive edge and after the request edge are not part of the latency
        if (kind == 0)
            check_count(cnt - 2, 2 * cur_t + 2, "command latency");
        @(posedge clk_2x);
        req <= '0;
        cnt = 0;
        idle_run = 0;
        while (idle_run < 3 && cnt < TIMEOUT)
        begin
            @(negedge clk_2x);
            idle_run = (pins == IDLE_PINS && status == '0) ? idle_run + 1 : 0;
            cnt++;
        end
        if (cnt >= TIMEOUT)
        begin
            $display("Error: timeout waiting for the bus to go idle after operation %0d", i);
            other_errs++;
            ok = 1'b0;
            return;
        end
        check_count(done_pulses, 1, "done pulses");
        check_count(we_rises, (kind == 0) ? 1 : (kind == 3) ? 0 : op_cnt[i], "web rises");
        check_count(re_rises, (kind == 3) ? op_cnt[i] : 0, "reb rises");
        check_count(rdy_rises, (kind == 2) ? op_cnt[i] : 0, "dat_rdy requests");
        check_count(wr_pulses, (kind == 3) ? op_cnt[i] : 0, "data_wr pulses");
    endtask

    initial
    begin
        int  seed_val;
        bit  ok;
        seed_val = $urandom(32'h2ef5);
        mismatch_errs = 0;
        other_errs    = 0;
        kind      = -1;
        cur_t     = 0;
        cur_h     = 0;
        low_len   = 0;
        since_fall = 0;
        src_busy  = 1'b0;
        stall     = 0;
        src_idx   = 0;
        we_rises  = 0;
        re_rises  = 0;
        prev_pins = IDLE_PINS;
        sink_s    = 1'b0;
        dat_rdy_s = 1'b0;
        rst_n    = 1'b0;
        req      = '0;
        if_cmd   = '0;
        col_addr = '0;
        row_addr = '0;
        addr_cnt = '0;
        dat_cnt  = '0;
        tconf    = '0;
        nf_din   = '0;
        mem_wr   = 1'b0;
        mem_din  = '0;
        sink_rdy = 1'b0;
        for (int k = 0; k < 4; k++)
            exp_words[k] = '0;
        read_trace();
        repeat (5) @(posedge clk_2x);
        rst_n <= 1'b1;
        @(negedge clk_2x);
        check_pins(pins, IDLE_PINS, "pins after reset");
        check_status(status, '0, "status after reset");
        check_word(DAT_WID'(dat_rdy), '0, "dat_rdy after reset");
        check_word(DAT_WID'(data_wr), '0, "data_wr after reset");
        ok = 1'b1;
        for (int i = 0; i < num_ops && ok; i++)
            run_op(i, ok);
        if (num_ops == 0)
        begin
            $display("Error: the trace holds no operations");
            other_errs++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== design/nfc_if_top.sv ====
/* NAND flash bus sequencer top, joins the FSM, strobe timing,
   address select and data path behind the register and memory ports */
module nfc_if_top
    import nfc_pkg::*;
#(
    parameter int DAT_WID = 16
)
(
    input  logic                    clk_2x,
    input  logic                    rst_n,
    // Register side
    input  nfc_req_t                req,
    input  logic [CMD_WID-1:0]      if_cmd,
    input  logic [31:0]             col_addr,
    input  logic [31:0]             row_addr,
    input  logic [ADDR_CNT_WID-1:0] addr_cnt,
    input  logic [DAT_CNT_WID-1:0]  dat_cnt,
    input  nfc_tconf_t              tconf,
    output nfif_status_t            status,
    // Flash side
    input  logic [DAT_WID-1:0]      nf_din,
    output logic [DAT_WID-1:0]      nf_dout,
    output nf_pins_t                pins,
    // Memory side
    output logic                    dat_rdy,
    input  logic                    mem_wr,
    input  logic [DAT_WID-1:0]      mem_din,
    input  logic                    sink_rdy,
    output logic                    data_wr,
    output logic [DAT_WID-1:0]      data_out
);

    nfif_state_e        state;
    logic               cycle_end;
    logic               byte_next;
    logic               word_taken;
    logic [CMD_WID-1:0] addr_byte;

    nfif_seq_fsm u_seq_fsm (
        .clk_2x     (clk_2x),
        .rst_n      (rst_n),
        .req        (req),
        .addr_cnt   (addr_cnt),
        .dat_cnt    (dat_cnt),
        .cycle_end  (cycle_end),
        .word_taken (word_taken),
        .sink_rdy   (sink_rdy),
        .state      (state),
        .status     (status),
        .byte_next  (byte_next),
        .dat_rdy    (dat_rdy)
    );

    nfif_strobe_gen u_strobe_gen (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .state     (state),
        .tconf     (tconf),
        .pins      (pins),
        .cycle_end (cycle_end)
    );

    nfif_addr_byte_sel u_addr_byte_sel (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .state     (state),
        .byte_next (byte_next),
        .col_addr  (col_addr),
        .row_addr  (row_addr),
        .addr_byte (addr_byte)
    );

    nfif_data_path #(
        .DAT_WID (DAT_WID)
    ) u_data_path (
        .clk_2x     (clk_2x),
        .rst_n      (rst_n),
        .state      (state),
        .pins       (pins),
        .if_cmd     (if_cmd),
        .addr_byte  (addr_byte),
        .nf_din     (nf_din),
        .mem_wr     (mem_wr),
        .mem_din    (mem_din),
        .nf_dout    (nf_dout),
        .word_taken (word_taken),
        .data_wr    (data_wr),
        .data_out   (data_out)
    );

endmodule

// ==== design/nfif_data_path.sv ====
/* Flash output data register, write word fetch and read capture
   toward the memory-side sink */
module nfif_data_path
    import nfc_pkg::*;
#(
    parameter int DAT_WID = 16
)
(
    input  logic               clk_2x,
    input  logic               rst_n,
    input  nfif_state_e        state,
    input  nf_pins_t           pins,
    input  logic [CMD_WID-1:0] if_cmd,
    input  logic [CMD_WID-1:0] addr_byte,
    input  logic [DAT_WID-1:0] nf_din,
    input  logic               mem_wr,
    input  logic [DAT_WID-1:0] mem_din,
    output logic [DAT_WID-1:0] nf_dout,
    output logic               word_taken,
    output logic               data_wr,
    output logic [DAT_WID-1:0] data_out
);

    logic reb_d;
    logic rd_rise;

    //////////////////////////////
    // Toward the flash
    //////////////////////////////
    // Address byte tracks the selector every cycle of the address phase
    always_ff @(posedge clk_2x)
    begin
        if (state == CMD_PRE)
            nf_dout <= DAT_WID'(if_cmd);
        else if (state inside {ADDR_PRE, ADDR_WR})
            nf_dout <= DAT_WID'(addr_byte);
        else if (mem_wr)
            nf_dout <= mem_din;
    end

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            word_taken <= 1'b0;
        else
            word_taken <= mem_wr;
    end

    //////////////////////////////
    // From the flash
    //////////////////////////////
    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            reb_d <= 1'b1;
        else
            reb_d <= pins.reb;
    end

    assign rd_rise = (state == DAT_RD) && pins.reb && !reb_d;

    // Sampled while RE# is low, so the value held is the one at the rising edge
    always_ff @(posedge clk_2x)
    begin
        if ((state == DAT_RD) && !pins.reb)
            data_out <= nf_din;
    end

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            data_wr <= 1'b0;
        else
            data_wr <= rd_rise;
    end

endmodule

// ==== design/nfif_addr_byte_sel.sv ====
/* Address byte index and column/row byte select, column bytes first,
   each word sent low byte first */
module nfif_addr_byte_sel
    import nfc_pkg::*;
(
    input  logic               clk_2x,
    input  logic               rst_n,
    input  nfif_state_e        state,
    input  logic               byte_next,
    input  logic [31:0]        col_addr,
    input  logic [31:0]        row_addr,
    output logic [CMD_WID-1:0] addr_byte
);

    logic [2:0]  byte_idx;
    logic [2:0]  sel_idx;
    logic [31:0] addr_word;

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            byte_idx <= '0;
        else if (state != ADDR_WR)
            byte_idx <= '0;
        else if (byte_next)
            byte_idx <= byte_idx + 1'b1;
    end

    // Look ahead on byte_next so the next byte is ready at the cycle boundary
    assign sel_idx   = byte_idx + {2'b00, byte_next};
    assign addr_word = sel_idx[2] ? row_addr : col_addr;

    always_comb
    begin
        case (sel_idx[1:0])
            2'd0:    addr_byte = addr_word[7:0];
            2'd1:    addr_byte = addr_word[15:8];
            2'd2:    addr_byte = addr_word[23:16];
            default: addr_byte = addr_word[31:24];
        endcase
    end

endmodule

// ==== design/nfif_strobe_gen.sv ====
/* Bus cycle timer and pin generation for CLE, ALE, WE#, RE# and bus direction */
module nfif_strobe_gen
    import nfc_pkg::*;
(
    input  logic        clk_2x,
    input  logic        rst_n,
    input  nfif_state_e state,
    input  nfc_tconf_t  tconf,
    output nf_pins_t    pins,
    output logic        cycle_end
);

    logic [T_CNT_WID-1:0] t_cnt;
    logic                 wr_active;
    logic                 rd_active;
    logic                 timed;
    logic                 strobe_hi;
    logic                 cle_q;
    logic                 ale_q;

    assign wr_active = state inside {CMD_WR, ADDR_WR, DAT_WR};
    assign rd_active = (state == DAT_RD);
    assign timed     = wr_active || rd_active;

    // Last clock of a 2T+2 cycle
    assign cycle_end = timed && (t_cnt == {tconf.total_cycle, 1'b1});

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            t_cnt <= '0;
        else if (!timed || cycle_end)
            t_cnt <= '0;
        else
            t_cnt <= t_cnt + 1'b1;
    end

    // High phase of the active strobe, always low in the first clock of a cycle
    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            strobe_hi <= 1'b0;
        else
            strobe_hi <= timed && !cycle_end && (t_cnt >= tconf.high_cycle);
    end

    // Latch enables span the whole operation up to END
    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cle_q <= 1'b0;
            ale_q <= 1'b0;
        end
        else if (state == END)
        begin
            cle_q <= 1'b0;
            ale_q <= 1'b0;
        end
        else
        begin
            if (state == CMD_PRE)
                cle_q <= 1'b1;
            if (state == ADDR_PRE)
                ale_q <= 1'b1;
        end
    end

    // Idle strobes sit high
    always_comb
    begin
        pins.cle = cle_q;
        pins.ale = ale_q;
        pins.web = !wr_active || strobe_hi;
        pins.reb = !rd_active || strobe_hi;
        pins.dir = state inside {CMD_WR, ADDR_WR, DAT_LD, DAT_WR};
    end

endmodule

// ==== design/nfif_seq_fsm.sv ====
/* Operation sequencer: picks a request, counts address bytes and data words,
   and reports completion with one-cycle done pulses */
module nfif_seq_fsm
    import nfc_pkg::*;
(
    input  logic                    clk_2x,
    input  logic                    rst_n,
    input  nfc_req_t                req,
    input  logic [ADDR_CNT_WID-1:0] addr_cnt,
    input  logic [DAT_CNT_WID-1:0]  dat_cnt,
    input  logic                    cycle_end,
    input  logic                    word_taken,
    input  logic                    sink_rdy,
    output nfif_state_e             state,
    output nfif_status_t            status,
    output logic                    byte_next,
    output logic                    dat_rdy
);

    nfif_state_e              state_nxt;
    logic [ADDR_CNT_WID-1:0]  byte_cnt;
    logic [DAT_CNT_WID-1:0]   word_cnt;
    logic                     last_byte;
    logic                     last_word;
    logic                     data_op;

    assign last_byte = (byte_cnt == addr_cnt - 1'b1);
    assign last_word = (word_cnt == dat_cnt - 1'b1);
    assign data_op   = state inside {DAT_LD, DAT_WR, DAT_HD, DAT_RD};

    // Done pulses land in the final cycle of the final bus cycle
    always_comb
    begin
        status.cmd_done  = (state == CMD_WR) && cycle_end;
        status.addr_done = (state == ADDR_WR) && cycle_end && last_byte;
        status.dat_done  = (state inside {DAT_WR, DAT_RD}) && cycle_end && last_word;
    end

    assign byte_next = (state == ADDR_WR) && cycle_end && !last_byte;

    // Drops as soon as the fetched word is seen
    assign dat_rdy = (state == DAT_LD) && !word_taken;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (req.cmd_en)
                    state_nxt = CMD_PRE;
                else if (req.addr_en)
                    state_nxt = ADDR_PRE;
                else if (req.dat_en && req.dat_dir)
                    state_nxt = DAT_LD;
                else if (req.dat_en)
                    state_nxt = DAT_HD;
            end
            CMD_PRE:
                state_nxt = CMD_WR;
            CMD_WR:
            begin
                if (cycle_end)
                    state_nxt = END;
            end
            ADDR_PRE:
                state_nxt = ADDR_WR;
            ADDR_WR:
            begin
                if (cycle_end && last_byte)
                    state_nxt = END;
            end
            DAT_LD:
            begin
                if (word_taken)
                    state_nxt = DAT_WR;
            end
            // One word in flight, so every write cycle goes back for the next
            DAT_WR:
            begin
                if (cycle_end)
                    state_nxt = last_word ? END : DAT_LD;
            end
            DAT_HD:
            begin
                if (sink_rdy)
                    state_nxt = DAT_RD;
            end
            DAT_RD:
            begin
                if (cycle_end && last_word)
                    state_nxt = END;
                else if (cycle_end && !sink_rdy)
                    state_nxt = DAT_HD;
            end
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    //////////////////////////////
    // Byte and word counters
    //////////////////////////////
    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            byte_cnt <= '0;
        else if (state != ADDR_WR)
            byte_cnt <= '0;
        else if (cycle_end)
            byte_cnt <= byte_cnt + 1'b1;
    end

    always_ff @(posedge clk_2x or negedge rst_n)
    begin
        if (!rst_n)
            word_cnt <= '0;
        else if (!data_op)
            word_cnt <= '0;
        else if (cycle_end)
            word_cnt <= word_cnt + 1'b1;
    end

endmodule

// ==== design/nfc_pkg.sv ====
/* Shared types and widths for the NAND flash bus sequencer
   Compiled first and imported by every design module */
package nfc_pkg;

    localparam int CMD_WID      = 8;
    localparam int ADDR_CNT_WID = 4;
    localparam int DAT_CNT_WID  = 14;
    localparam int T_CNT_WID    = 4;

    // Sequencer states
    typedef enum logic [3:0] {
        IDLE     = 4'h0,
        CMD_PRE  = 4'h1,
        CMD_WR   = 4'h2,
        ADDR_PRE = 4'h3,
        ADDR_WR  = 4'h4,
        DAT_LD   = 4'h5,
        DAT_WR   = 4'h6,
        DAT_HD   = 4'h7,
        DAT_RD   = 4'h8,
        END      = 4'h9
    } nfif_state_e;

    // Requests from the register block, dat_dir 1 is a flash write
    typedef struct packed {
        logic cmd_en;
        logic addr_en;
        logic dat_en;
        logic dat_dir;
    } nfc_req_t;

    // Bus cycle is 2*total_cycle+2 clocks
    typedef struct packed {
        logic [2:0] total_cycle;
        logic [3:0] high_cycle;
    } nfc_tconf_t;

    typedef struct packed {
        logic cle;
        logic ale;
        logic web;
        logic reb;
        logic dir;
    } nf_pins_t;

    typedef struct packed {
        logic cmd_done;
        logic addr_done;
        logic dat_done;
    } nfif_status_t;

endpackage
